/* hdl/cu_pkg.sv */
package cu_pkg;

	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	localparam opcode_t OP_R_TYPE = 6'b000000;
	localparam opcode_t OP_ADDI   = 6'b001000;
	localparam opcode_t OP_ADDIU  = 6'b001001;
	localparam opcode_t OP_BEQ    = 6'b000100;
	localparam opcode_t OP_BNE    = 6'b000101;
	localparam opcode_t OP_BLE    = 6'b000110;
	localparam opcode_t OP_BGT    = 6'b000111;
	localparam opcode_t OP_SW     = 6'b101011;
	localparam opcode_t OP_SH     = 6'b101001;
	localparam opcode_t OP_SB     = 6'b101000;

	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRAV = 6'b000111;

	typedef enum logic [4:0] {
		CLS_ADD,
		CLS_SUB,
		CLS_AND,
		CLS_SLT,
		CLS_SLL,
		CLS_SRL,
		CLS_SRA,
		CLS_SLLV,
		CLS_SRAV,
		CLS_ADDI,
		CLS_ADDIU,
		CLS_BRANCH_EQ, // beq and bne
		CLS_BRANCH_GT, // ble and bgt
		CLS_SW,
		CLS_SH,
		CLS_SB,
		CLS_NONE
	} instr_class_t;

	typedef enum logic [5:0] {
		ST_FETCH_1      = 6'd1,
		ST_FETCH_2      = 6'd2,
		ST_FETCH_3      = 6'd3,
		ST_DECODE_1     = 6'd4,
		ST_DECODE_2     = 6'd5,
		ST_ADD          = 6'd6,
		ST_SUB          = 6'd7,
		ST_AND          = 6'd8,
		ST_ALU_WB       = 6'd9,
		ST_SHIFT_SHAMT  = 6'd10,
		ST_SLL          = 6'd11, // also sllv
		ST_SRA          = 6'd12, // also srav
		ST_SRL          = 6'd13,
		ST_SHIFT_REG    = 6'd14,
		ST_SHIFT_WB     = 6'd15,
		ST_SLT          = 6'd16,
		ST_ADDI_ADDIU   = 6'd17,
		ST_ADDI         = 6'd18,
		ST_ADDIU        = 6'd19,
		ST_BEQ_BNE_1    = 6'd20,
		ST_BEQ_BNE_2    = 6'd21,
		ST_BLE_BGT_1    = 6'd22,
		ST_BLE_BGT_2    = 6'd23,
		ST_STORE_1      = 6'd24,
		ST_STORE_2      = 6'd25,
		ST_STORE_3      = 6'd26,
		ST_SW           = 6'd27,
		ST_SH           = 6'd28,
		ST_SB           = 6'd29,
		ST_CLOSE        = 6'd63
	} state_t;

	typedef enum logic [2:0] {
		ALU_LOAD = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_SUB  = 3'd2,
		ALU_AND  = 3'd3,
		ALU_CMP  = 3'd7 // equal / greater / less compare
	} alu_op_t;

	typedef enum logic [2:0] {
		SHIFT_NONE        = 3'd0,
		SHIFT_LOAD        = 3'd1,
		SHIFT_LEFT        = 3'd2,
		SHIFT_RIGHT_LOG   = 3'd3,
		SHIFT_RIGHT_ARITH = 3'd4
	} shift_op_t;

	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		STORE_WORD = 2'd1,
		STORE_HALF = 2'd2,
		STORE_BYTE = 2'd3
	} store_size_t;

	// register file write data select
	localparam logic [2:0] MEM_TO_REG_ALU   = 3'd0;
	localparam logic [2:0] MEM_TO_REG_CMP   = 3'd4;
	localparam logic [2:0] MEM_TO_REG_SHIFT = 3'd5;
	localparam logic [2:0] MEM_TO_REG_INIT  = 3'd7; // initial stack pointer

	// register file destination select
	localparam logic [1:0] REG_DIST_RT = 2'd0;
	localparam logic [1:0] REG_DIST_RA = 2'd1;
	localparam logic [1:0] REG_DIST_SP = 2'd2;
	localparam logic [1:0] REG_DIST_RD = 2'd3;

endpackage

/* hdl/cu_instr_decode.sv */
`timescale 1ns/1ps

module cu_instr_decode (
	input  cu_pkg::opcode_t      i_op_code,
	input  cu_pkg::funct_t       i_funct,
	input  logic                 i_equal,
	input  logic                 i_greater,
	output cu_pkg::instr_class_t o_instr_class,
	output logic                 o_branch_taken
);

	import cu_pkg::*;

	always_comb begin
		o_instr_class = CLS_NONE; // unknown codes fall through to close
		case (i_op_code)
			OP_R_TYPE: begin
				case (i_funct)
					FN_ADD:  o_instr_class = CLS_ADD;
					FN_SUB:  o_instr_class = CLS_SUB;
					FN_AND:  o_instr_class = CLS_AND;
					FN_SLT:  o_instr_class = CLS_SLT;
					FN_SLL:  o_instr_class = CLS_SLL;
					FN_SRL:  o_instr_class = CLS_SRL;
					FN_SRA:  o_instr_class = CLS_SRA;
					FN_SLLV: o_instr_class = CLS_SLLV;
					FN_SRAV: o_instr_class = CLS_SRAV;
					default: o_instr_class = CLS_NONE;
				endcase
			end
			OP_ADDI:  o_instr_class = CLS_ADDI;
			OP_ADDIU: o_instr_class = CLS_ADDIU;
			OP_BEQ,
			OP_BNE:   o_instr_class = CLS_BRANCH_EQ;
			OP_BLE,
			OP_BGT:   o_instr_class = CLS_BRANCH_GT;
			OP_SW:    o_instr_class = CLS_SW;
			OP_SH:    o_instr_class = CLS_SH;
			OP_SB:    o_instr_class = CLS_SB;
			default:  o_instr_class = CLS_NONE;
		endcase
	end

	// flags come from the datapath comparator
	always_comb begin
		case (i_op_code)
			OP_BEQ:  o_branch_taken = i_equal;
			OP_BNE:  o_branch_taken = !i_equal;
			OP_BGT:  o_branch_taken = i_greater;
			OP_BLE:  o_branch_taken = !i_greater;
			default: o_branch_taken = 1'b0;
		endcase
	end

endmodule

/* hdl/cu_state_sequencer.sv */
`timescale 1ns/1ps

module cu_state_sequencer (
	input  logic                 clock,
	input  logic                 reset,
	input  cu_pkg::instr_class_t i_instr_class,
	output cu_pkg::state_t       o_state
);

	import cu_pkg::*;

	state_t state_q;
	state_t state_nx;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ST_FETCH_1;
		end else begin
			state_q <= state_nx;
		end
	end

	always_comb begin
		state_nx = ST_CLOSE;
		case (state_q)
			ST_FETCH_1: state_nx = ST_FETCH_2;
			ST_FETCH_2: state_nx = ST_FETCH_3;
			ST_FETCH_3: state_nx = ST_DECODE_1;
			ST_DECODE_1: state_nx = ST_DECODE_2;
			ST_DECODE_2: begin
				case (i_instr_class)
					CLS_ADD: state_nx = ST_ADD;
					CLS_SUB: state_nx = ST_SUB;
					CLS_AND: state_nx = ST_AND;
					CLS_SLT: state_nx = ST_SLT;
					CLS_SLL,
					CLS_SRL,
					CLS_SRA: state_nx = ST_SHIFT_SHAMT;
					CLS_SLLV,
					CLS_SRAV: state_nx = ST_SHIFT_REG;
					CLS_ADDI,
					CLS_ADDIU: state_nx = ST_ADDI_ADDIU;
					CLS_BRANCH_EQ: state_nx = ST_BEQ_BNE_1;
					CLS_BRANCH_GT: state_nx = ST_BLE_BGT_1;
					CLS_SW,
					CLS_SH,
					CLS_SB: state_nx = ST_STORE_1;
					default: state_nx = ST_CLOSE;
				endcase
			end
			ST_ADD,
			ST_SUB,
			ST_AND: state_nx = ST_ALU_WB;
			ST_SHIFT_SHAMT: begin
				case (i_instr_class)
					CLS_SLL: state_nx = ST_SLL;
					CLS_SRL: state_nx = ST_SRL;
					default: state_nx = ST_SRA;
				endcase
			end
			ST_SHIFT_REG: begin
				// only sllv and srav reach here
				state_nx = (i_instr_class == CLS_SLLV) ? ST_SLL : ST_SRA;
			end
			ST_SLL,
			ST_SRA,
			ST_SRL: state_nx = ST_SHIFT_WB;
			ST_ADDI_ADDIU: begin
				state_nx = (i_instr_class == CLS_ADDIU) ? ST_ADDIU : ST_ADDI;
			end
			ST_BEQ_BNE_1: state_nx = ST_BEQ_BNE_2;
			ST_BLE_BGT_1: state_nx = ST_BLE_BGT_2;
			ST_STORE_1: state_nx = ST_STORE_2;
			ST_STORE_2: state_nx = ST_STORE_3;
			ST_STORE_3: begin
				case (i_instr_class)
					CLS_SW:  state_nx = ST_SW;
					CLS_SH:  state_nx = ST_SH;
					CLS_SB:  state_nx = ST_SB;
					default: state_nx = ST_CLOSE;
				endcase
			end
			ST_CLOSE: state_nx = ST_FETCH_1;
			default: state_nx = ST_CLOSE; // write-back and store states end here too
		endcase
	end

	assign o_state = state_q;

endmodule

/* hdl/cu_control_word.sv */
`timescale 1ns/1ps

module cu_control_word (
	input  logic                clock,
	input  logic                reset,
	input  cu_pkg::state_t      i_state,
	input  logic                i_branch_taken,
	output logic                o_ir_write,
	output logic                o_pc_write,
	output logic                o_memory_write,
	output logic                o_reg_write,
	output logic                o_a_b_write,
	output logic [1:0]          o_i_or_d,
	output logic                o_mem_data_write,
	output logic [1:0]          o_pc_source,
	output logic                o_alu_src_a,
	output cu_pkg::alu_op_t     o_alu_op,
	output logic                o_alu_out_write,
	output logic [1:0]          o_alu_src_b,
	output logic [2:0]          o_mem_to_reg,
	output logic [1:0]          o_reg_dist_ctrl,
	output logic                o_shift_src_control,
	output cu_pkg::shift_op_t   o_shift_control,
	output cu_pkg::store_size_t o_store_size_control
);

	import cu_pkg::*;

	typedef struct packed {
		logic        ir_write;
		logic        pc_write;
		logic        memory_write;
		logic        reg_write;
		logic        a_b_write;
		logic [1:0]  i_or_d;
		logic        mem_data_write;
		logic [1:0]  pc_source;
		logic        alu_src_a;
		alu_op_t     alu_op;
		logic        alu_out_write;
		logic [1:0]  alu_src_b;
		logic [2:0]  mem_to_reg;
		logic [1:0]  reg_dist_ctrl;
		logic        shift_src_control;
		shift_op_t   shift_control;
		store_size_t store_size;
	} ctrl_word_t;

	ctrl_word_t cw_nx;
	ctrl_word_t cw_q;

	always_comb begin
		cw_nx = '0;
		cw_nx.alu_op = ALU_LOAD;
		cw_nx.shift_control = SHIFT_NONE;
		cw_nx.store_size = STORE_NONE;
		cw_nx.mem_to_reg = MEM_TO_REG_ALU;
		cw_nx.reg_dist_ctrl = REG_DIST_RT;
		case (i_state)
			ST_FETCH_1, ST_FETCH_2, ST_FETCH_3: begin
				cw_nx.alu_op = ALU_ADD; // pc + 4
				cw_nx.alu_src_b = 2'd1;
				cw_nx.pc_write = (i_state == ST_FETCH_2);
				cw_nx.ir_write = (i_state == ST_FETCH_3);
			end
			ST_DECODE_1: begin
				cw_nx.alu_op = ALU_ADD; // branch target
				cw_nx.alu_src_b = 2'd3;
				cw_nx.a_b_write = 1'b1;
				cw_nx.alu_out_write = 1'b1;
			end
			ST_DECODE_2: cw_nx.alu_op = ALU_ADD;
			ST_ADD, ST_SUB, ST_AND: begin
				cw_nx.alu_op = (i_state == ST_ADD) ? ALU_ADD :
					(i_state == ST_SUB) ? ALU_SUB : ALU_AND;
				cw_nx.alu_src_a = 1'b1;
				cw_nx.alu_out_write = 1'b1;
			end
			ST_ALU_WB: begin
				cw_nx.reg_write = 1'b1;
				cw_nx.reg_dist_ctrl = REG_DIST_RD;
			end
			ST_SLT: begin
				cw_nx.alu_op = ALU_CMP;
				cw_nx.alu_src_a = 1'b1;
				cw_nx.reg_write = 1'b1;
				cw_nx.mem_to_reg = MEM_TO_REG_CMP;
				cw_nx.reg_dist_ctrl = REG_DIST_RD;
			end
			ST_SHIFT_SHAMT, ST_SHIFT_REG: begin
				cw_nx.shift_control = SHIFT_LOAD;
				cw_nx.shift_src_control = (i_state == ST_SHIFT_SHAMT); // amount from shamt
			end
			ST_SLL: cw_nx.shift_control = SHIFT_LEFT;
			ST_SRL: cw_nx.shift_control = SHIFT_RIGHT_LOG;
			ST_SRA: cw_nx.shift_control = SHIFT_RIGHT_ARITH;
			ST_SHIFT_WB: begin
				cw_nx.reg_write = 1'b1;
				cw_nx.mem_to_reg = MEM_TO_REG_SHIFT;
				cw_nx.reg_dist_ctrl = REG_DIST_RD;
			end
			ST_ADDI_ADDIU: begin
				cw_nx.alu_op = ALU_ADD;
				cw_nx.alu_src_a = 1'b1;
				cw_nx.alu_src_b = 2'd2; // sign extended immediate
				cw_nx.alu_out_write = 1'b1;
			end
			ST_ADDI: begin
				cw_nx.alu_src_a = 1'b1;
				cw_nx.alu_src_b = 2'd2;
				cw_nx.alu_out_write = 1'b1;
				cw_nx.reg_write = 1'b1;
			end
			ST_ADDIU: cw_nx.reg_write = 1'b1;
			ST_BEQ_BNE_1, ST_BEQ_BNE_2, ST_BLE_BGT_1, ST_BLE_BGT_2: begin
				cw_nx.alu_op = ALU_CMP;
				cw_nx.alu_src_a = 1'b1;
				cw_nx.pc_source = 2'd1; // target held in alu_out
				cw_nx.i_or_d = (i_state == ST_BLE_BGT_1 || i_state == ST_BLE_BGT_2) ?
					2'd1 : 2'd0;
				cw_nx.pc_write = (i_state == ST_BEQ_BNE_2 || i_state == ST_BLE_BGT_2) &&
					i_branch_taken;
			end
			ST_STORE_1, ST_STORE_2, ST_STORE_3: begin
				cw_nx.alu_op = ALU_ADD; // base + offset
				cw_nx.alu_src_a = 1'b1;
				cw_nx.alu_src_b = 2'd2;
				cw_nx.i_or_d = 2'd1;
				cw_nx.alu_out_write = (i_state == ST_STORE_1);
				cw_nx.mem_data_write = (i_state == ST_STORE_3);
			end
			ST_SW, ST_SH, ST_SB: begin
				cw_nx.alu_op = ALU_ADD;
				cw_nx.i_or_d = 2'd1;
				cw_nx.memory_write = 1'b1;
				cw_nx.store_size = (i_state == ST_SW) ? STORE_WORD :
					(i_state == ST_SH) ? STORE_HALF : STORE_BYTE;
			end
			default: cw_nx.alu_op = ALU_LOAD; // close is all idle
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			cw_q <= '0;
			cw_q.reg_write <= 1'b1; // load initial sp
			cw_q.mem_to_reg <= MEM_TO_REG_INIT;
			cw_q.reg_dist_ctrl <= REG_DIST_SP;
		end else begin
			cw_q <= cw_nx;
		end
	end

	assign o_ir_write           = cw_q.ir_write;
	assign o_pc_write           = cw_q.pc_write;
	assign o_memory_write       = cw_q.memory_write;
	assign o_reg_write          = cw_q.reg_write;
	assign o_a_b_write          = cw_q.a_b_write;
	assign o_i_or_d             = cw_q.i_or_d;
	assign o_mem_data_write     = cw_q.mem_data_write;
	assign o_pc_source          = cw_q.pc_source;
	assign o_alu_src_a          = cw_q.alu_src_a;
	assign o_alu_op             = cw_q.alu_op;
	assign o_alu_out_write      = cw_q.alu_out_write;
	assign o_alu_src_b          = cw_q.alu_src_b;
	assign o_mem_to_reg         = cw_q.mem_to_reg;
	assign o_reg_dist_ctrl      = cw_q.reg_dist_ctrl;
	assign o_shift_src_control  = cw_q.shift_src_control;
	assign o_shift_control      = cw_q.shift_control;
	assign o_store_size_control = cw_q.store_size;

endmodule

/* hdl/ctrl_unit.sv */
`timescale 1ns/1ps

module ctrl_unit (
	input  logic                clock,
	input  logic                reset,
	input  cu_pkg::opcode_t     i_op_code,
	input  cu_pkg::funct_t      i_funct,
	input  logic                i_equal,
	input  logic                i_greater,
	output logic                o_ir_write,
	output logic                o_pc_write,
	output logic                o_memory_write,
	output logic                o_reg_write,
	output logic                o_a_b_write,
	output logic [1:0]          o_i_or_d,
	output logic                o_mem_data_write,
	output logic [1:0]          o_pc_source,
	output logic                o_alu_src_a,
	output cu_pkg::alu_op_t     o_alu_op,
	output logic                o_alu_out_write,
	output logic [1:0]          o_alu_src_b,
	output logic [2:0]          o_mem_to_reg,
	output logic [1:0]          o_reg_dist_ctrl,
	output logic                o_shift_src_control,
	output cu_pkg::shift_op_t   o_shift_control,
	output cu_pkg::store_size_t o_store_size_control
);

	import cu_pkg::*;

	instr_class_t instr_class;
	logic         branch_taken;
	state_t       state;

	cu_instr_decode cu_instr_decode_i (
		.i_op_code      (i_op_code),
		.i_funct        (i_funct),
		.i_equal        (i_equal),
		.i_greater      (i_greater),
		.o_instr_class  (instr_class),
		.o_branch_taken (branch_taken)
	);

	cu_state_sequencer cu_state_sequencer_i (
		.clock         (clock),
		.reset         (reset),
		.i_instr_class (instr_class),
		.o_state       (state)
	);

	cu_control_word cu_control_word_i (
		.clock                (clock),
		.reset                (reset),
		.i_state              (state),
		.i_branch_taken       (branch_taken),
		.o_ir_write           (o_ir_write),
		.o_pc_write           (o_pc_write),
		.o_memory_write       (o_memory_write),
		.o_reg_write          (o_reg_write),
		.o_a_b_write          (o_a_b_write),
		.o_i_or_d             (o_i_or_d),
		.o_mem_data_write     (o_mem_data_write),
		.o_pc_source          (o_pc_source),
		.o_alu_src_a          (o_alu_src_a),
		.o_alu_op             (o_alu_op),
		.o_alu_out_write      (o_alu_out_write),
		.o_alu_src_b          (o_alu_src_b),
		.o_mem_to_reg         (o_mem_to_reg),
		.o_reg_dist_ctrl      (o_reg_dist_ctrl),
		.o_shift_src_control  (o_shift_src_control),
		.o_shift_control      (o_shift_control),
		.o_store_size_control (o_store_size_control)
	);

endmodule

/* test/ctrl_unit_assertions.sv */
`timescale 1ns/1ps

module ctrl_unit_assertions (
	input logic clock,
	input logic reset,
	input logic i_ir_write,
	input logic i_pc_write,
	input logic i_memory_write,
	input logic i_reg_write,
	input logic i_a_b_write
);

	int failures = 0; // read by the testbench top

	no_store_during_reg_write: assert property (@(posedge clock) disable iff (reset)
		!(i_memory_write && i_reg_write))
		else begin
			$error("memory_write and reg_write high in the same cycle");
			failures++;
		end

	no_pc_write_during_fetch: assert property (@(posedge clock) disable iff (reset)
		!(i_pc_write && i_ir_write))
		else begin
			$error("pc_write and ir_write high in the same cycle");
			failures++;
		end

	operands_follow_fetch: assert property (@(posedge clock) disable iff (reset)
		i_ir_write |=> i_a_b_write)
		else begin
			$error("a_b_write missing one cycle after ir_write");
			failures++;
		end

	operands_only_after_fetch: assert property (@(posedge clock) disable iff (reset)
		i_a_b_write |-> $past(i_ir_write))
		else begin
			$error("a_b_write without ir_write in the cycle before");
			failures++;
		end

endmodule

bind cu_control_word ctrl_unit_assertions ctrl_unit_assertions_i (
	.clock          (clock),
	.reset          (reset),
	.i_ir_write     (o_ir_write),
	.i_pc_write     (o_pc_write),
	.i_memory_write (o_memory_write),
	.i_reg_write    (o_reg_write),
	.i_a_b_write    (o_a_b_write)
);

/* test/ctrl_unit_checker.sv */
`timescale 1ns/1ps

module ctrl_unit_checker (
	input  logic                clock,
	input  logic                reset,
	input  cu_pkg::opcode_t     i_op_code,
	input  cu_pkg::funct_t      i_funct,
	input  logic                i_equal,
	input  logic                i_greater,
	input  logic                i_ir_write,
	input  logic                i_pc_write,
	input  logic                i_memory_write,
	input  logic                i_reg_write,
	input  logic                i_a_b_write,
	input  logic [1:0]          i_i_or_d,
	input  logic                i_mem_data_write,
	input  logic [1:0]          i_pc_source,
	input  logic                i_alu_src_a,
	input  cu_pkg::alu_op_t     i_alu_op,
	input  logic                i_alu_out_write,
	input  logic [1:0]          i_alu_src_b,
	input  logic [2:0]          i_mem_to_reg,
	input  logic [1:0]          i_reg_dist_ctrl,
	input  logic                i_shift_src_control,
	input  cu_pkg::shift_op_t   i_shift_control,
	input  cu_pkg::store_size_t i_store_size_control,
	output int                  o_tests_done,
	output int                  o_tests_failed
);

	import cu_pkg::*;

	// bit positions in the write strobe vector
	localparam int IR  = 5;
	localparam int PC  = 4;
	localparam int MEM = 3;
	localparam int REG = 2;
	localparam int AB  = 1;
	localparam int MDW = 0;

	instr_class_t cls;
	int           pos; // cycle within the instruction, 0 is the ir_write cycle
	int           seq_len;
	int           errors;
	bit           startup;
	bit           taken;
	string        test_name;
	logic [5:0]   exp_strobes;

	function automatic instr_class_t classify(input opcode_t op, input funct_t fn);
		if (op != OP_R_TYPE) begin
			case (op)
				OP_ADDI: return CLS_ADDI;
				OP_ADDIU: return CLS_ADDIU;
				OP_BEQ, OP_BNE: return CLS_BRANCH_EQ;
				OP_BLE, OP_BGT: return CLS_BRANCH_GT;
				OP_SW: return CLS_SW;
				OP_SH: return CLS_SH;
				OP_SB: return CLS_SB;
				default: return CLS_NONE;
			endcase
		end
		case (fn)
			FN_ADD: return CLS_ADD;
			FN_SUB: return CLS_SUB;
			FN_AND: return CLS_AND;
			FN_SLT: return CLS_SLT;
			FN_SLL: return CLS_SLL;
			FN_SRL: return CLS_SRL;
			FN_SRA: return CLS_SRA;
			FN_SLLV: return CLS_SLLV;
			FN_SRAV: return CLS_SRAV;
			default: return CLS_NONE;
		endcase
	endfunction

	// ir_write to ir_write distance
	function automatic int cycles_of(input instr_class_t c);
		case (c)
			CLS_SLT: return 7;
			CLS_SLL, CLS_SRL, CLS_SRA, CLS_SLLV, CLS_SRAV: return 9;
			CLS_SW, CLS_SH, CLS_SB: return 10;
			CLS_NONE: return 6;
			default: return 8;
		endcase
	endfunction

	function automatic bit branch_rule(input opcode_t op, input logic eq, input logic gt);
		if (op == OP_BEQ)
			return eq;
		if (op == OP_BNE)
			return !eq;
		if (op == OP_BGT)
			return gt;
		if (op == OP_BLE)
			return !gt;
		return 1'b0;
	endfunction

	task automatic compare_field(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s %s: expected 'h%0h actual 'h%0h",
				test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic reset_word_rules();
		exp_strobes[REG] = 1'b1; // initial stack pointer load
		compare_field("mem_to_reg", MEM_TO_REG_INIT, i_mem_to_reg);
		compare_field("reg_dist_ctrl", REG_DIST_SP, i_reg_dist_ctrl);
		compare_field("idle controls", '0, {i_i_or_d, i_pc_source, i_alu_src_a, i_alu_op,
			i_alu_out_write, i_alu_src_b, i_shift_src_control, i_shift_control,
			i_store_size_control});
	endtask

	task automatic fetch_rules();
		compare_field("alu_op", ALU_ADD, i_alu_op);
		compare_field("alu_src_b", 1, i_alu_src_b);
		if (pos == 0)
			exp_strobes[IR] = 1'b1;
		if (pos == seq_len - 1) begin
			exp_strobes[PC] = 1'b1; // pc + 4
			compare_field("pc_source", 0, i_pc_source);
		end
	endtask

	task automatic exec_rules(input int step);
		case (cls)
			CLS_ADD, CLS_SUB, CLS_AND: begin
				if (step == 0) begin
					compare_field("alu_op", (cls == CLS_ADD) ? ALU_ADD :
						(cls == CLS_SUB) ? ALU_SUB : ALU_AND, i_alu_op);
					compare_field("alu_src_a", 1, i_alu_src_a);
					compare_field("alu_out_write", 1, i_alu_out_write);
				end else begin
					exp_strobes[REG] = 1'b1;
					compare_field("reg_dist_ctrl", REG_DIST_RD, i_reg_dist_ctrl);
					compare_field("mem_to_reg", MEM_TO_REG_ALU, i_mem_to_reg);
				end
			end
			CLS_SLT: begin
				exp_strobes[REG] = 1'b1; // compare and write back in one cycle
				compare_field("alu_op", ALU_CMP, i_alu_op);
				compare_field("reg_dist_ctrl", REG_DIST_RD, i_reg_dist_ctrl);
				compare_field("mem_to_reg", MEM_TO_REG_CMP, i_mem_to_reg);
			end
			CLS_SLL, CLS_SRL, CLS_SRA, CLS_SLLV, CLS_SRAV: begin
				if (step == 0) begin
					compare_field("shift_control", SHIFT_LOAD, i_shift_control);
					compare_field("shift_src_control",
						cls == CLS_SLL || cls == CLS_SRL || cls == CLS_SRA, i_shift_src_control);
				end else if (step == 1) begin
					compare_field("shift_control", (cls == CLS_SLL || cls == CLS_SLLV) ?
						SHIFT_LEFT : (cls == CLS_SRL) ? SHIFT_RIGHT_LOG : SHIFT_RIGHT_ARITH,
						i_shift_control);
				end else begin
					exp_strobes[REG] = 1'b1;
					compare_field("mem_to_reg", MEM_TO_REG_SHIFT, i_mem_to_reg);
				end
			end
			CLS_ADDI, CLS_ADDIU: begin
				if (step == 1) begin
					exp_strobes[REG] = 1'b1;
					compare_field("reg_dist_ctrl", REG_DIST_RT, i_reg_dist_ctrl);
				end
			end
			CLS_BRANCH_EQ, CLS_BRANCH_GT: begin
				compare_field("alu_op", ALU_CMP, i_alu_op);
				if (step == 1)
					exp_strobes[PC] = taken;
			end
			CLS_SW, CLS_SH, CLS_SB: begin
				if (step == 2) begin
					exp_strobes[MDW] = 1'b1;
				end else if (step == 3) begin
					exp_strobes[MEM] = 1'b1;
					compare_field("i_or_d", 1, i_i_or_d);
					compare_field("store_size_control", (cls == CLS_SW) ? STORE_WORD :
						(cls == CLS_SH) ? STORE_HALF : STORE_BYTE, i_store_size_control);
				end
			end
			default: ;
		endcase
	endtask

	// outputs settle after the rising edge, so everything is sampled at the falling one
	always @(negedge clock) begin
		if (reset) begin
			o_tests_done = 0;
			o_tests_failed = 0;
			errors = 0;
			startup = 1'b1;
			cls = CLS_NONE;
			seq_len = cycles_of(CLS_NONE);
			pos = 3; // the reset word sits where the closing state would be
			test_name = "reset";
		end else begin
			exp_strobes = '0;
			if (pos == 0)
				test_name = $sformatf("instr_%0d", o_tests_done);
			if (pos == 1) begin
				cls = classify(i_op_code, i_funct); // held by the datapath from here on
				seq_len = cycles_of(cls);
				taken = branch_rule(i_op_code, i_equal, i_greater);
				test_name = $sformatf("instr_%0d_%s", o_tests_done, cls.name());
			end
			if (startup && pos == 3) begin
				reset_word_rules();
			end else if (pos == 0 || pos >= seq_len - 2) begin
				fetch_rules();
			end else if (pos == 1) begin
				exp_strobes[AB] = 1'b1;
				compare_field("alu_out_write", 1, i_alu_out_write);
			end else if (pos >= 3 && pos < seq_len - 3) begin
				exec_rules(pos - 3);
			end
			compare_field("write strobes", exp_strobes, {i_ir_write, i_pc_write,
				i_memory_write, i_reg_write, i_a_b_write, i_mem_data_write});
			if (pos == seq_len - 1) begin
				if (errors == 0) begin
					$display("%-28s pass", test_name);
				end else begin
					$display("%-28s FAIL with %0d bad checks", test_name, errors);
					o_tests_failed++;
				end
				o_tests_done++;
				errors = 0;
				startup = 1'b0;
				pos = 0;
			end else begin
				pos++;
			end
		end
	end

endmodule

/* test/ctrl_unit_tb.sv */
`timescale 1ns/1ps

module ctrl_unit_tb;

	import cu_pkg::*;

	localparam int NUM_INSTR = 400;
	localparam int TIMEOUT_NS = NUM_INSTR * 10 * 10 + 2000; // longest instruction is 10 cycles

	logic        clock;
	logic        reset;
	opcode_t     op_code;
	funct_t      funct;
	logic        equal;
	logic        greater;
	logic        ir_write;
	logic        pc_write;
	logic        memory_write;
	logic        reg_write;
	logic        a_b_write;
	logic [1:0]  i_or_d;
	logic        mem_data_write;
	logic [1:0]  pc_source;
	logic        alu_src_a;
	alu_op_t     alu_op;
	logic        alu_out_write;
	logic [1:0]  alu_src_b;
	logic [2:0]  mem_to_reg;
	logic [1:0]  reg_dist_ctrl;
	logic        shift_src_control;
	shift_op_t   shift_control;
	store_size_t store_size_control;
	int          tests_done;
	int          tests_failed;
	int          assert_failures;
	int          sent;
	logic [31:0] rng;
	opcode_t     other_ops [9];
	funct_t      listed_functs [9];

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic bit is_listed_opcode(input opcode_t op);
		if (op == OP_R_TYPE)
			return 1'b1;
		for (int i = 0; i < 9; i++) begin
			if (other_ops[i] == op)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic drive_next_instruction();
		opcode_t op;
		funct_t  fn;
		rng = xorshift(rng);
		if (rng % 10 == 0) begin
			op = rng[21:16];
			while (is_listed_opcode(op)) begin
				rng = xorshift(rng);
				op = rng[21:16];
			end
		end else if (rng[8]) begin
			op = OP_R_TYPE; // about half, so every funct shows up often
		end else begin
			op = other_ops[rng[15:9] % 9];
		end
		rng = xorshift(rng);
		fn = (rng % 10 == 9) ? funct_t'(rng[21:16]) : listed_functs[rng[15:8] % 9];
		op_code <= op;
		funct <= fn;
		equal <= rng[3];
		greater <= rng[4];
		sent++;
	endtask

	always #5 clock = ~clock;

	// next instruction goes out on the edge that ends the ir_write cycle
	always @(posedge clock) begin
		if (!reset && ir_write && sent < NUM_INSTR)
			drive_next_instruction();
	end

	ctrl_unit ctrl_unit_i (
		.clock                (clock),
		.reset                (reset),
		.i_op_code            (op_code),
		.i_funct              (funct),
		.i_equal              (equal),
		.i_greater            (greater),
		.o_ir_write           (ir_write),
		.o_pc_write           (pc_write),
		.o_memory_write       (memory_write),
		.o_reg_write          (reg_write),
		.o_a_b_write          (a_b_write),
		.o_i_or_d             (i_or_d),
		.o_mem_data_write     (mem_data_write),
		.o_pc_source          (pc_source),
		.o_alu_src_a          (alu_src_a),
		.o_alu_op             (alu_op),
		.o_alu_out_write      (alu_out_write),
		.o_alu_src_b          (alu_src_b),
		.o_mem_to_reg         (mem_to_reg),
		.o_reg_dist_ctrl      (reg_dist_ctrl),
		.o_shift_src_control  (shift_src_control),
		.o_shift_control      (shift_control),
		.o_store_size_control (store_size_control)
	);

	ctrl_unit_checker ctrl_unit_checker_i (
		.clock                (clock),
		.reset                (reset),
		.i_op_code            (op_code),
		.i_funct              (funct),
		.i_equal              (equal),
		.i_greater            (greater),
		.i_ir_write           (ir_write),
		.i_pc_write           (pc_write),
		.i_memory_write       (memory_write),
		.i_reg_write          (reg_write),
		.i_a_b_write          (a_b_write),
		.i_i_or_d             (i_or_d),
		.i_mem_data_write     (mem_data_write),
		.i_pc_source          (pc_source),
		.i_alu_src_a          (alu_src_a),
		.i_alu_op             (alu_op),
		.i_alu_out_write      (alu_out_write),
		.i_alu_src_b          (alu_src_b),
		.i_mem_to_reg         (mem_to_reg),
		.i_reg_dist_ctrl      (reg_dist_ctrl),
		.i_shift_src_control  (shift_src_control),
		.i_shift_control      (shift_control),
		.i_store_size_control (store_size_control),
		.o_tests_done         (tests_done),
		.o_tests_failed       (tests_failed)
	);

	initial begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns, only %0d of %0d instructions were checked",
			TIMEOUT_NS, tests_done, NUM_INSTR + 1);
		$display("tests failed");
		$finish;
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		op_code = OP_R_TYPE;
		funct = FN_ADD;
		equal = 1'b0;
		greater = 1'b0;
		sent = 0;
		rng = 32'd32;
		other_ops = '{OP_ADDI, OP_ADDIU, OP_BEQ, OP_BNE, OP_BLE, OP_BGT, OP_SW, OP_SH, OP_SB};
		listed_functs = '{FN_ADD, FN_SUB, FN_AND, FN_SLT, FN_SLL, FN_SRL, FN_SRA, FN_SLLV,
			FN_SRAV};
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		wait (tests_done == NUM_INSTR + 1); // reset word plus every instruction
		assert_failures = ctrl_unit_i.cu_control_word_i.ctrl_unit_assertions_i.failures;
		$display("summary: %0d run, %0d passed, %0d failed, %0d assertion failures",
			tests_done, tests_done - tests_failed, tests_failed, assert_failures);
		if (tests_failed == 0 && assert_failures == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* files.f */
hdl/cu_pkg.sv
hdl/cu_instr_decode.sv
hdl/cu_state_sequencer.sv
hdl/cu_control_word.sv
hdl/ctrl_unit.sv
test/ctrl_unit_assertions.sv
test/ctrl_unit_checker.sv
test/ctrl_unit_tb.sv

/* Bender.yml */
package:
  name: ctrl_unit

sources:
  - hdl/cu_pkg.sv
  - hdl/cu_instr_decode.sv
  - hdl/cu_state_sequencer.sv
  - hdl/cu_control_word.sv
  - hdl/ctrl_unit.sv
  - target: test
    files:
      - test/ctrl_unit_assertions.sv
      - test/ctrl_unit_checker.sv
      - test/ctrl_unit_tb.sv
